// File: ex_stage.f
+incdir+.
ex_pkg.sv
ex_decode.sv
ex_alu.sv
ex_branch_unit.sv
ex_mem_req.sv
ex_stage.sv
tb_clk_gen.sv
ex_stage_assert.sv
tb_ex_stage.sv

// File: run.sh
#!/bin/bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -f ex_stage.f --top-module tb_ex_stage -o sim_ex_stage

./obj_dir/sim_ex_stage | tee sim.log

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi
exit 0

// File: tb_ex_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "ex_macros.svh"

module tb_ex_stage import ex_pkg::*; ();

    localparam int RST_CYC  = 4;
    localparam int DIR_CYC  = 120;
    localparam int N_RAND   = 300;
    localparam int WD_CYC   = RST_CYC + DIR_CYC + 2 * N_RAND + 50;

    logic     clk;
    logic     rst_n;
    logic     valid_i;
    ex_req_t  req_i;
    logic     valid_o;
    wb_t      wb_o;
    jump_t    jump_o;
    mem_req_t mem_o;
    int       err_cnt;
    int       chk_cnt;

    logic [6:0] opc_tab [12] = '{`OPC_OP, `OPC_OP_W, `OPC_OP_IMM, `OPC_OP_IMM_W,
                                 `OPC_BRANCH, `OPC_LOAD, `OPC_STORE, `OPC_JAL,
                                 `OPC_JALR, `OPC_LUI, `OPC_AUIPC, 7'b1111111};

    tb_clk_gen #(.PERIOD(100), .RST_CYC(RST_CYC)) u_clk (.clk_o(clk), .rst_n_o(rst_n));

    ex_stage ex_stage_i (
        .clk     (clk),
        .rst_n_i (rst_n),
        .valid_i (valid_i),
        .req_i   (req_i),
        .valid_o (valid_o),
        .wb_o    (wb_o),
        .jump_o  (jump_o),
        .mem_o   (mem_o)
    );

    function automatic ex_req_t make_req(input logic [6:0] opc, input logic [2:0] f3,
                                         input logic alt, input logic [63:0] a,
                                         input logic [63:0] b);
        ex_req_t r;
        r         = '0;
        r.inst    = {1'b0, alt, 5'b0, 5'd2, 5'd1, f3, 5'd5, opc};
        r.pc      = 64'h1000;
        r.op1     = a;
        r.op2     = b;
        r.rd      = 5'd5;
        r.reg_wen = 1'b1;
        r.base    = a;
        r.offset  = b;
        return r;
    endfunction

    function automatic ex_req_t rand_req();
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic [63:0] a;
        logic [63:0] b;
        int          pick;
        ex_req_t     r;
        opc = opc_tab[$urandom % 12];
        f3  = 3'($urandom);
        if (opc == `OPC_OP_W || opc == `OPC_OP_IMM_W) begin
            pick = $urandom % 3;
            f3   = (pick == 0) ? 3'b000 : (pick == 1) ? 3'b001 : 3'b101;
        end
        if (opc == `OPC_STORE) f3[2] = 1'b0;
        a    = {$urandom, $urandom};
        pick = $urandom % 4;
        b    = (pick == 0) ? a : (pick == 1) ? a ^ 64'h8000_0000_0000_0000
                                             : {$urandom, $urandom};
        r           = make_req(opc, f3, 1'($urandom), a, b);
        r.rd        = 5'($urandom);
        r.reg_wen   = ($urandom % 8) != 0;
        r.offset    = {$urandom, $urandom};
        return r;
    endfunction

    task automatic drive(input ex_req_t r);
        @(posedge clk);
        valid_i <= 1'b1;
        req_i   <= r;
    endtask

    // one strobe, then wait for its result
    task automatic send_wait(input ex_req_t r);
        bit found;
        found = 1'b0;
        drive(r);
        @(posedge clk);
        valid_i <= 1'b0;
        for (int n = 0; n < 4 && !found; n++) begin
            @(negedge clk);
            found = valid_o;
        end
        if (!found) begin
            $display("no result appeared for a spot check instruction");
            err_cnt++;
        end
    endtask

    initial begin
        void'($urandom(78814));
        err_cnt = 0;
        valid_i = 1'b0;
        req_i   = '0;
        @(posedge rst_n);
        for (int f = 0; f < 8; f++) begin
            drive(make_req(`OPC_OP, 3'(f), 1'b0, 64'hffff_0000_1234_5678, 64'd67));
            drive(make_req(`OPC_OP_IMM, 3'(f), 1'b1, 64'h8000_0000_0000_0001, 64'd3));
            drive(make_req(`OPC_LOAD, 3'(f), 1'b0, 64'h2000, 64'h18));
        end
        drive(make_req(`OPC_OP, 3'b000, 1'b1, 64'd5, 64'd9));
        drive(make_req(`OPC_OP, 3'b101, 1'b1, 64'h8000_0000_0000_0000, 64'd68));
        foreach (opc_tab[i]) begin
            if (opc_tab[i] == `OPC_OP_W || opc_tab[i] == `OPC_OP_IMM_W) begin
                for (int s = 0; s < 2; s++) begin
                    drive(make_req(opc_tab[i], 3'b000, 1'(s), 64'h7fff_ffff, 64'd1));
                    drive(make_req(opc_tab[i], 3'b001, 1'(s), 64'h1, 64'd63));
                    drive(make_req(opc_tab[i], 3'b101, 1'(s), 64'h8000_00f0, 64'd36));
                end
            end
        end
        for (int f = 0; f < 8; f++) begin
            drive(make_req(`OPC_BRANCH, 3'(f), 1'b0, 64'h8000_0000_0000_0001, 64'd1));
            drive(make_req(`OPC_BRANCH, 3'(f), 1'b0, 64'd7, 64'd7));
        end
        for (int f = 0; f < 4; f++)
            drive(make_req(`OPC_STORE, 3'(f), 1'b0, 64'h0123_4567_89ab_cdef, 64'h40));
        drive(make_req(`OPC_JAL, 3'b000, 1'b0, 64'h1000, 64'd4));
        drive(make_req(`OPC_JALR, 3'b000, 1'b0, 64'h3000, 64'd4));
        drive(make_req(`OPC_LUI, 3'b000, 1'b0, 64'h1, 64'hffff_ffff_8765_4000));
        drive(make_req(`OPC_AUIPC, 3'b000, 1'b0, 64'h1000, 64'h2000));
        drive(make_req(7'b1111111, 3'b000, 1'b0, 64'h1, 64'h1));

        // spot checks
        send_wait(make_req(`OPC_OP_W, 3'b000, 1'b0, 64'h7fff_ffff, 64'd1));
        if (wb_o.wdata != 64'hffff_ffff_8000_0000) begin
            $display("ERR %0t: addw sign extension wrong", $time);
            err_cnt++;
        end
        send_wait(make_req(`OPC_STORE, 3'b000, 1'b0, 64'h1234, 64'h5a5a));
        if (mem_o.wmask != 8'h01 || mem_o.wdata != 64'h5a || mem_o.addr != 64'h6c8e) begin
            $display("ERR %0t: sb request wrong", $time);
            err_cnt++;
        end
        send_wait(make_req(`OPC_BRANCH, 3'b110, 1'b0, 64'd1, 64'hffff_ffff_ffff_fff0));
        if (!jump_o.en || jump_o.addr != 64'hffff_ffff_ffff_fff1) begin
            $display("ERR %0t: bltu not taken", $time);
            err_cnt++;
        end

        for (int i = 0; i < N_RAND; i++) begin
            drive(rand_req());
            if ($urandom % 4 == 0) begin
                @(posedge clk);
                valid_i <= 1'b0;
                req_i   <= rand_req();  // ignored while idle
            end
        end
        @(posedge clk);
        valid_i <= 1'b0;
        repeat (3) @(posedge clk);

        chk_cnt = ex_stage_i.u_chk.fail_cnt;
        $display("errors: tb %0d, assertions %0d", err_cnt, chk_cnt);
        if (err_cnt == 0 && chk_cnt == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #(WD_CYC * 100);
        $display("watchdog expired, the run did not finish in time");
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: ex_stage_assert.sv
`timescale 1ns/1ps
`default_nettype none

`include "ex_macros.svh"

module ex_stage_assert import ex_pkg::*; (
    input logic     clk,
    input logic     rst_n_i,
    input logic     valid_i,
    input ex_req_t  req_i,
    input logic     valid_o,
    input wb_t      wb_o,
    input jump_t    jump_o,
    input mem_req_t mem_o
);

    int fail_cnt = 0;

    logic          v_q;
    ex_req_t       r_q;     // request of the previous cycle
    logic [6:0]    opc;
    logic [2:0]    f3;
    logic          is_ar;
    logic          e_wen;
    logic          e_wchk;  // load data is not known here
    logic [63:0]   e_wdata;
    logic          e_jen;
    logic          e_jaddr;
    logic          e_ren;
    logic          e_mwen;
    logic [63:0]   e_mdata;
    logic [7:0]    e_mask;
    logic [63:0]   ea;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            v_q <= 1'b0;
            r_q <= '0;
        end else begin
            v_q <= valid_i;
            r_q <= req_i;
        end
    end

    function automatic logic [63:0] exp_result(input ex_req_t r);
        logic [6:0]  c;
        logic [2:0]  f;
        logic        sub_ok;
        logic [31:0] a32;
        logic [31:0] b32;
        logic [31:0] w;
        logic [63:0] a;
        logic [63:0] b;
        c = r.inst.r_view.opcode;
        f = r.inst.r_view.funct3;
        a = r.op1;
        b = r.op2;
        sub_ok = (c == `OPC_OP || c == `OPC_OP_W) && r.inst.r_view.funct7[5];
        if (c == `OPC_LUI) return b;
        if (c != `OPC_OP && c != `OPC_OP_W && c != `OPC_OP_IMM && c != `OPC_OP_IMM_W)
            return a + b;  // auipc and the link value
        if (c == `OPC_OP_W || c == `OPC_OP_IMM_W) begin
            a32 = a[31:0];
            b32 = b[31:0];
            case (f)
                3'b000:  w = sub_ok ? a32 - b32 : a32 + b32;
                3'b001:  w = a32 << b32[4:0];
                3'b101: begin
                    if (r.inst.r_view.funct7[5])
                        w = $signed(a32) >>> b32[4:0];
                    else
                        w = a32 >> b32[4:0];
                end
                default: w = '0;
            endcase
            return {{32{w[31]}}, w};
        end
        case (f)
            3'b000:  return sub_ok ? a - b : a + b;
            3'b001:  return a << b[5:0];
            3'b010:  return {63'b0, $signed(a) < $signed(b)};
            3'b011:  return {63'b0, a < b};
            3'b100:  return a ^ b;
            3'b101: begin
                if (r.inst.r_view.funct7[5])
                    return $signed(a) >>> b[5:0];
                return a >> b[5:0];
            end
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    always_comb begin
        opc     = r_q.inst.r_view.opcode;
        f3      = r_q.inst.r_view.funct3;
        ea      = r_q.base + r_q.offset;
        is_ar   = opc == `OPC_OP || opc == `OPC_OP_W || opc == `OPC_OP_IMM ||
                  opc == `OPC_OP_IMM_W || opc == `OPC_LUI || opc == `OPC_AUIPC;
        e_wen   = r_q.reg_wen & (is_ar | opc == `OPC_JAL | opc == `OPC_JALR |
                                 opc == `OPC_LOAD);
        e_wchk  = e_wen & (opc != `OPC_LOAD);
        e_wdata = exp_result(r_q);
        e_jaddr = opc == `OPC_BRANCH || opc == `OPC_JAL || opc == `OPC_JALR;
        e_jen   = opc == `OPC_JAL || opc == `OPC_JALR;
        if (opc == `OPC_BRANCH) begin
            case (f3)
                3'b000:  e_jen = r_q.op1 == r_q.op2;
                3'b001:  e_jen = r_q.op1 != r_q.op2;
                3'b100:  e_jen = $signed(r_q.op1) < $signed(r_q.op2);
                3'b101:  e_jen = $signed(r_q.op1) >= $signed(r_q.op2);
                3'b110:  e_jen = r_q.op1 < r_q.op2;
                3'b111:  e_jen = r_q.op1 >= r_q.op2;
                default: e_jen = 1'b0;
            endcase
        end
        e_ren  = opc == `OPC_LOAD;
        e_mwen = opc == `OPC_STORE && !f3[2];
        case (f3[1:0])
            2'b00:   e_mdata = {56'b0, r_q.op2[7:0]};
            2'b01:   e_mdata = {48'b0, r_q.op2[15:0]};
            2'b10:   e_mdata = {32'b0, r_q.op2[31:0]};
            default: e_mdata = r_q.op2;
        endcase
        e_mask = 8'hff >> (8 - (1 << f3[1:0]));
    end

    a_idle: assert property (@(posedge clk)
        !valid_o |-> !(wb_o.wen || jump_o.en || mem_o.ren || mem_o.wen))
        else begin
            fail_cnt++;
            $error("enable raised while valid_o is low");
        end

    a_valid: assert property (@(posedge clk) disable iff (!rst_n_i) valid_o == v_q)
        else begin
            fail_cnt++;
            $error("valid_o does not follow valid_i");
        end

    a_wb: assert property (@(posedge clk) disable iff (!rst_n_i)
        valid_o |-> wb_o.wen == e_wen && (!e_wen || wb_o.rd == r_q.rd) &&
                    (!e_wchk || wb_o.wdata == e_wdata))
        else begin
            fail_cnt++;
            $error("write-back mismatch");
        end

    a_jump: assert property (@(posedge clk) disable iff (!rst_n_i)
        valid_o |-> jump_o.en == e_jen && (!e_jaddr || jump_o.addr == ea))
        else begin
            fail_cnt++;
            $error("jump mismatch");
        end

    a_mem: assert property (@(posedge clk) disable iff (!rst_n_i)
        valid_o |-> mem_o.ren == e_ren && mem_o.wen == e_mwen &&
                    (!(e_ren || e_mwen) || mem_o.addr == ea) &&
                    (!e_mwen || (mem_o.wdata == e_mdata && mem_o.wmask == e_mask)))
        else begin
            fail_cnt++;
            $error("memory request mismatch");
        end

endmodule

bind ex_stage ex_stage_assert u_chk (.*);

`default_nettype wire

// File: tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD  = 100,
    parameter int RST_CYC = 4
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial clk_o = 1'b0;
    always #(PERIOD / 2) clk_o = ~clk_o;

    initial begin
        rst_n_o = 1'b0;
        repeat (RST_CYC) @(posedge clk_o);
        rst_n_o <= 1'b1;  // released on the 4th edge
    end

endmodule

`default_nettype wire

// File: ex_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "ex_macros.svh"

module ex_stage import ex_pkg::*; (
    input  logic     clk,
    input  logic     rst_n_i,
    input  logic     valid_i,
    input  ex_req_t  req_i,
    output logic     valid_o,
    output wb_t      wb_o,
    output jump_t    jump_o,
    output mem_req_t mem_o
);

    ctrl_t               ctrl;
    logic [`EX_XLEN-1:0] alu_res;
    wb_t                 wb_d;
    jump_t               jump_d;
    mem_req_t            mem_d;

    // registered enables
    logic valid_q;
    logic wb_wen_q;
    logic jump_en_q;
    logic mem_ren_q;
    logic mem_wen_q;

    // registered payload
    logic [`EX_RAW-1:0]   wb_rd_q;
    logic [`EX_XLEN-1:0]  wb_wdata_q;
    logic [`EX_XLEN-1:0]  jump_addr_q;
    logic [`EX_XLEN-1:0]  mem_addr_q;
    logic [`EX_XLEN-1:0]  mem_wdata_q;
    logic [`EX_MASKW-1:0] mem_wmask_q;

    ex_decode u_decode (
        .inst_i (req_i.inst),
        .ctrl_o (ctrl)
    );

    ex_alu u_alu (
        .op1_i     (req_i.op1),
        .op2_i     (req_i.op2),
        .alu_op_i  (ctrl.alu_op),
        .is_word_i (ctrl.is_word),
        .result_o  (alu_res)
    );

    ex_branch_unit u_branch (
        .op1_i       (req_i.op1),
        .op2_i       (req_i.op2),
        .base_i      (req_i.base),
        .offset_i    (req_i.offset),
        .funct3_i    (req_i.inst.r_view.funct3),
        .is_branch_i (ctrl.is_branch),
        .is_jump_i   (ctrl.is_jump),
        .jump_o      (jump_d)
    );

    ex_mem_req u_mem_req (
        .base_i     (req_i.base),
        .offset_i   (req_i.offset),
        .op2_i      (req_i.op2),
        .funct3_i   (req_i.inst.r_view.funct3),
        .is_load_i  (ctrl.is_load),
        .is_store_i (ctrl.is_store),
        .mem_o      (mem_d)
    );

    // only alu ops, links and loads write rd; load data arrives later
    assign wb_d.wen   = req_i.reg_wen & (ctrl.is_alu | ctrl.is_jump | ctrl.is_load);
    assign wb_d.rd    = req_i.rd;
    assign wb_d.wdata = alu_res;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q   <= 1'b0;
            wb_wen_q  <= 1'b0;
            jump_en_q <= 1'b0;
            mem_ren_q <= 1'b0;
            mem_wen_q <= 1'b0;
        end else begin
            valid_q   <= valid_i;
            wb_wen_q  <= valid_i & wb_d.wen;  // idle cycles raise nothing
            jump_en_q <= valid_i & jump_d.en;
            mem_ren_q <= valid_i & mem_d.ren;
            mem_wen_q <= valid_i & mem_d.wen;
        end
    end

    always_ff @(posedge clk) begin
        if (valid_i) begin
            wb_rd_q     <= wb_d.rd;
            wb_wdata_q  <= wb_d.wdata;
            jump_addr_q <= jump_d.addr;
            mem_addr_q  <= mem_d.addr;
            mem_wdata_q <= mem_d.wdata;
            mem_wmask_q <= mem_d.wmask;
        end
    end

    assign valid_o = valid_q;
    assign wb_o    = '{wen: wb_wen_q, rd: wb_rd_q, wdata: wb_wdata_q};
    assign jump_o  = '{en: jump_en_q, addr: jump_addr_q};
    assign mem_o   = '{ren: mem_ren_q, wen: mem_wen_q, addr: mem_addr_q,
                       wdata: mem_wdata_q, wmask: mem_wmask_q};

endmodule

`default_nettype wire

// File: ex_mem_req.sv
`timescale 1ns/1ps
`default_nettype none

`include "ex_macros.svh"

module ex_mem_req import ex_pkg::*; (
    input  logic [`EX_XLEN-1:0] base_i,
    input  logic [`EX_XLEN-1:0] offset_i,
    input  logic [`EX_XLEN-1:0] op2_i,
    input  logic [2:0]          funct3_i,
    input  logic                is_load_i,
    input  logic                is_store_i,
    output mem_req_t            mem_o
);

    logic [`EX_XLEN-1:0] eff_addr;

    assign eff_addr = base_i + offset_i;

    always_comb begin
        mem_o = '0;
        if (is_load_i) begin
            // load width and sign are handled when the data returns
            mem_o.ren  = 1'b1;
            mem_o.addr = eff_addr;
        end else if (is_store_i) begin
            mem_o.addr = eff_addr;
            mem_o.wen  = 1'b1;
            case (funct3_i)
                `F3_SB: begin
                    mem_o.wdata = {56'b0, op2_i[7:0]};
                    mem_o.wmask = `MASK_B;
                end
                `F3_SH: begin
                    mem_o.wdata = {48'b0, op2_i[15:0]};
                    mem_o.wmask = `MASK_H;
                end
                `F3_SW: begin
                    mem_o.wdata = {32'b0, op2_i[31:0]};
                    mem_o.wmask = `MASK_W;
                end
                `F3_SD: begin
                    mem_o.wdata = op2_i;
                    mem_o.wmask = `MASK_D;
                end
                default: mem_o = '0;  // no such store size
            endcase
        end
    end

endmodule

`default_nettype wire

// File: ex_branch_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "ex_macros.svh"

module ex_branch_unit import ex_pkg::*; (
    input  logic [`EX_XLEN-1:0] op1_i,
    input  logic [`EX_XLEN-1:0] op2_i,
    input  logic [`EX_XLEN-1:0] base_i,
    input  logic [`EX_XLEN-1:0] offset_i,
    input  logic [2:0]          funct3_i,
    input  logic                is_branch_i,
    input  logic                is_jump_i,
    output jump_t               jump_o
);

    logic [`EX_XLEN-1:0] target;
    logic                eq;
    logic                lt_s;
    logic                lt_u;
    logic                taken;

    assign target = base_i + offset_i;  // pc+imm, or rs1+imm for jalr
    assign eq     = (op1_i == op2_i);
    assign lt_s   = $signed(op1_i) < $signed(op2_i);
    assign lt_u   = op1_i < op2_i;

    always_comb begin
        taken = 1'b0;
        if (is_jump_i) begin
            taken = 1'b1;
        end else if (is_branch_i) begin
            case (funct3_i)
                `F3_BEQ:  taken = eq;
                `F3_BNE:  taken = ~eq;
                `F3_BLT:  taken = lt_s;
                `F3_BGE:  taken = ~lt_s;
                `F3_BLTU: taken = lt_u;
                `F3_BGEU: taken = ~lt_u;
                default:  taken = 1'b0;  // 010/011 are not branches
            endcase
        end
    end

    assign jump_o.en   = taken;
    assign jump_o.addr = (is_branch_i | is_jump_i) ? target : '0;

endmodule

`default_nettype wire

// File: ex_alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "ex_macros.svh"

module ex_alu import ex_pkg::*; (
    input  logic [`EX_XLEN-1:0] op1_i,
    input  logic [`EX_XLEN-1:0] op2_i,
    input  alu_op_e             alu_op_i,
    input  logic                is_word_i,
    output logic [`EX_XLEN-1:0] result_o
);

    logic                sign_fill;  // sraw needs the word sign above bit 31
    logic [`EX_XLEN-1:0] opa;
    logic [5:0]          shamt;
    logic [`EX_XLEN-1:0] res;

    always_comb begin
        sign_fill = is_word_i & (alu_op_i == SRA) & op1_i[`EX_WLEN-1];
        opa = is_word_i ? {{(`EX_XLEN-`EX_WLEN){sign_fill}}, op1_i[`EX_WLEN-1:0]} : op1_i;
        shamt = is_word_i ? {1'b0, op2_i[4:0]} : op2_i[5:0];

        case (alu_op_i)
            ADD:    res = opa + op2_i;
            SUB:    res = opa - op2_i;
            SLT:    res = {{(`EX_XLEN-1){1'b0}}, $signed(opa) < $signed(op2_i)};
            SLTU:   res = {{(`EX_XLEN-1){1'b0}}, opa < op2_i};
            XOR:    res = opa ^ op2_i;
            OR:     res = opa | op2_i;
            AND:    res = opa & op2_i;
            SLL:    res = opa << shamt;
            SRL:    res = opa >> shamt;  // upper word is zero for srlw
            SRA:    res = $signed(opa) >>> shamt;
            PASS_B: res = op2_i;
            default: res = '0;
        endcase

        // low word is right for every op above, widen it back
        if (is_word_i) begin
            result_o = {{(`EX_XLEN-`EX_WLEN){res[`EX_WLEN-1]}}, res[`EX_WLEN-1:0]};
        end else begin
            result_o = res;
        end
    end

endmodule

`default_nettype wire

// File: ex_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "ex_macros.svh"

module ex_decode import ex_pkg::*; (
    input  inst_u inst_i,
    output ctrl_t ctrl_o
);

    // funct3 to alu op; sub_bit only matters for add, sra_bit for shifts right
    function automatic alu_op_e map_op(input logic [2:0] f3, input logic sub_bit,
                                       input logic sra_bit);
        alu_op_e op;
        case (f3)
            `F3_ADD:  op = sub_bit ? SUB : ADD;
            `F3_SLL:  op = SLL;
            `F3_SLT:  op = SLT;
            `F3_SLTU: op = SLTU;
            `F3_XOR:  op = XOR;
            `F3_SR:   op = sra_bit ? SRA : SRL;
            `F3_OR:   op = OR;
            default:  op = AND;
        endcase
        return op;
    endfunction

    logic [2:0] funct3;
    logic       r_alt;   // funct7[5] of register ops
    logic       i_alt;   // shift type bit, just above the shamt

    assign funct3 = inst_i.r_view.funct3;
    assign r_alt  = inst_i.r_view.funct7[5];
    assign i_alt  = inst_i.i_view.imm12[10];

    always_comb begin
        ctrl_o        = '0;
        ctrl_o.alu_op = ADD;
        case (inst_i.r_view.opcode)
            `OPC_OP: begin
                ctrl_o.is_alu = 1'b1;
                ctrl_o.alu_op = map_op(funct3, r_alt, r_alt);
            end
            `OPC_OP_W: begin
                ctrl_o.is_alu  = 1'b1;
                ctrl_o.is_word = 1'b1;
                ctrl_o.alu_op  = map_op(funct3, r_alt, r_alt);
            end
            `OPC_OP_IMM: begin
                ctrl_o.is_alu = 1'b1;
                ctrl_o.alu_op = map_op(funct3, 1'b0, i_alt); // no subi
            end
            `OPC_OP_IMM_W: begin
                ctrl_o.is_alu  = 1'b1;
                ctrl_o.is_word = 1'b1;
                ctrl_o.alu_op  = map_op(funct3, 1'b0, i_alt);
            end
            `OPC_LUI: begin
                ctrl_o.is_alu = 1'b1;
                ctrl_o.alu_op = PASS_B;  // imm already shifted in op2
            end
            `OPC_AUIPC: ctrl_o.is_alu = 1'b1;  // pc + imm
            `OPC_JAL,
            `OPC_JALR:   ctrl_o.is_jump = 1'b1;  // link pc+4 through the adder
            `OPC_BRANCH: ctrl_o.is_branch = 1'b1;
            `OPC_LOAD:   ctrl_o.is_load = 1'b1;
            `OPC_STORE:  ctrl_o.is_store = 1'b1;
            default: ;  // unknown opcode, nothing raised
        endcase
    end

endmodule

`default_nettype wire

// File: ex_pkg.sv
`default_nettype none

`include "ex_macros.svh"

package ex_pkg;

    // register format view
    typedef struct packed {
        logic [6:0]          funct7;
        logic [`EX_RAW-1:0]  rs2;
        logic [`EX_RAW-1:0]  rs1;
        logic [2:0]          funct3;
        logic [`EX_RAW-1:0]  rd;
        logic [6:0]          opcode;
    } inst_r_t;

    // immediate format view, shamt sits in imm12[5:0]
    typedef struct packed {
        logic [11:0]         imm12;
        logic [`EX_RAW-1:0]  rs1;
        logic [2:0]          funct3;
        logic [`EX_RAW-1:0]  rd;
        logic [6:0]          opcode;
    } inst_i_t;

    typedef union packed {
        inst_r_t r_view;
        inst_i_t i_view;
    } inst_u;

    typedef enum logic [3:0] {
        ADD, SUB, SLT, SLTU, XOR, OR, AND, SLL, SRL, SRA, PASS_B
    } alu_op_e;

    // operands come already selected by the decode stage
    typedef struct packed {
        inst_u               inst;
        logic [`EX_XLEN-1:0] pc;
        logic [`EX_XLEN-1:0] op1;
        logic [`EX_XLEN-1:0] op2;
        logic [`EX_RAW-1:0]  rd;
        logic                reg_wen;
        logic [`EX_XLEN-1:0] base;    // address base for mem and jumps
        logic [`EX_XLEN-1:0] offset;
    } ex_req_t;

    typedef struct packed {
        alu_op_e alu_op;
        logic    is_word;
        logic    is_alu;     // also lui and auipc
        logic    is_branch;
        logic    is_jump;    // jal, jalr
        logic    is_load;
        logic    is_store;
    } ctrl_t;

    typedef struct packed {
        logic                wen;
        logic [`EX_RAW-1:0]  rd;
        logic [`EX_XLEN-1:0] wdata;
    } wb_t;

    typedef struct packed {
        logic                en;
        logic [`EX_XLEN-1:0] addr;
    } jump_t;

    typedef struct packed {
        logic                 ren;
        logic                 wen;
        logic [`EX_XLEN-1:0]  addr;
        logic [`EX_XLEN-1:0]  wdata;
        logic [`EX_MASKW-1:0] wmask;
    } mem_req_t;

endpackage

`default_nettype wire

// File: ex_macros.svh
`ifndef EX_MACROS_SVH
`define EX_MACROS_SVH

// datapath widths
`define EX_XLEN  64
`define EX_WLEN  32  // W forms work on the low word
`define EX_RAW   5
`define EX_MASKW 8

// major opcodes
`define OPC_OP_IMM   7'b0010011
`define OPC_OP_IMM_W 7'b0011011
`define OPC_OP       7'b0110011
`define OPC_OP_W     7'b0111011
`define OPC_BRANCH   7'b1100011
`define OPC_LOAD     7'b0000011
`define OPC_STORE    7'b0100011
`define OPC_JAL      7'b1101111
`define OPC_JALR     7'b1100111
`define OPC_LUI      7'b0110111
`define OPC_AUIPC    7'b0010111

// arithmetic funct3
`define F3_ADD  3'b000
`define F3_SLL  3'b001
`define F3_SLT  3'b010
`define F3_SLTU 3'b011
`define F3_XOR  3'b100
`define F3_SR   3'b101  // srl and sra share it
`define F3_OR   3'b110
`define F3_AND  3'b111

// branch funct3
`define F3_BEQ  3'b000
`define F3_BNE  3'b001
`define F3_BLT  3'b100
`define F3_BGE  3'b101
`define F3_BLTU 3'b110
`define F3_BGEU 3'b111

// access size funct3, loads use the same low two bits
`define F3_SB 3'b000
`define F3_SH 3'b001
`define F3_SW 3'b010
`define F3_SD 3'b011

// right aligned byte masks
`define MASK_B 8'h01
`define MASK_H 8'h03
`define MASK_W 8'h0f
`define MASK_D 8'hff

`endif
